// File: verification/matmul_testdata.hex
// Word 0 is the case count. Each case: dims packed as in REG_DIMS, src1 base, src2 base,
// dest base, then source 1, source 2 and the expected results, all row-major
00000005
// Square 2x2 times 2x2
00020202 00000000 00000000 00000004
0001 0002
0003 0004
0005 0006
0007 0008
00000013 00000016
0000002b 00000032
// Rectangular 2x3 times 3x2 at nonzero bases
00020302 00000010 00000020 00000040
0001 0002 0003
0004 0005 0006
0007 0008
0009 000a
000b 000c
0000003a 00000040
0000008b 0000009a
// Outer product 3x1 times 1x3
00030103 00000050 00000060 00000080
0002
0003
0004
0005 0006 0007
0000000a 0000000c 0000000e
0000000f 00000012 00000015
00000014 00000018 0000001c
// Dot product 1x4 times 4x1 whose sum wraps modulo 2^32
00010401 00000100 00000200 00000300
ffff ffff ffff ffff
ffff
ffff
ffff
ffff
fff80004
// Zero rows, nothing may be written around dest base 5
00020200 00000000 000003f0 00000005
0101 0202
0303 0404

// File: all.f
hdl/mm_types_pkg.sv
hdl/mm_axil_pkg.sv
hdl/scratch_ram.sv
hdl/mm_csr_axil.sv
hdl/mm_sequencer.sv
hdl/operand_fetch.sv
hdl/dot_mac.sv
hdl/matmul_top.sv
verification/matmul_props.sv
verification/matmul_tb.sv

// File: verification/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb;
    import mm_axil_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DATA_WORDS = 128;
    localparam int MEM_DEPTH  = 1024;

    logic        clk;
    logic        reset;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic [31:0] tdata [0:DATA_WORDS-1];
    logic [31:0] dest_model [0:MEM_DEPTH-1];   // X where no job has written yet
    int          errors;
    int          checks;
    int          budget;
    logic        budget_ready;

    matmul_top #(.MEM_DEPTH(MEM_DEPTH)) uut (
        .clk(clk),
        .reset(reset),
        .axil_req(req),
        .axil_rsp(rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [15:0] win_addr(input logic [15:0] base, input int word);
        return base + 16'(word * 4);
    endfunction

    // Ready is sampled 1 ns after the falling edge, so the next rising edge sees the same value
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        logic aw_fire, w_fire, b_fire;
        @(negedge clk);
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        req.wvalid  = 1'b1;
        req.bready  = 1'b1;
        b_fire      = 1'b0;
        while (req.awvalid || req.wvalid) begin
            #1;
            aw_fire = req.awvalid && rsp.awready;
            w_fire  = req.wvalid && rsp.wready;
            @(negedge clk);
            if (aw_fire) req.awvalid = 1'b0;
            if (w_fire) req.wvalid = 1'b0;
        end
        while (!b_fire) begin
            #1;
            b_fire = rsp.bvalid;
            resp   = rsp.bresp;
            @(negedge clk);
        end
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic ar_fire, r_fire;
        @(negedge clk);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b1;
        r_fire      = 1'b0;
        while (req.arvalid) begin
            #1;
            ar_fire = rsp.arready;
            @(negedge clk);
            if (ar_fire) req.arvalid = 1'b0;
        end
        while (!r_fire) begin
            #1;
            r_fire = rsp.rvalid;
            data   = rsp.rdata;
            resp   = rsp.rresp;
            @(negedge clk);
        end
        req.rready = 1'b0;
    endtask

    task automatic write_expect(input logic [15:0] addr, input logic [31:0] data,
                                input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check($sformatf("bresp@%h", addr), exp_resp, resp);
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check($sformatf("rresp@%h", addr), exp_resp, resp);
        check(name, exp_data, data);
    endtask

    task automatic run_case(input int p);
        logic [31:0] dims, status;
        logic [1:0]  resp;
        int rows1, cols1, cols2, n1, n2, nres, steps;
        int src1_base, src2_base, dest_base, res_ptr, guard_lo, idx;
        dims      = tdata[p];
        rows1     = dims[5:0];
        cols1     = dims[13:8];
        cols2     = dims[21:16];
        src1_base = tdata[p+1];
        src2_base = tdata[p+2];
        dest_base = tdata[p+3];
        n1        = rows1 * cols1;
        n2        = cols1 * cols2;
        nres      = rows1 * cols2;
        steps     = nres * cols1;
        res_ptr   = p + 4 + n1 + n2;
        guard_lo  = dest_base - 2;                   // Two untouched words on each side
        for (idx = 0; idx < n1; idx++) begin
            write_expect(win_addr(WIN_SRC1, src1_base + idx),
                         {16'hBEEF, tdata[p+4+idx][15:0]}, resp_okay);
        end
        for (idx = 0; idx < n2; idx++) begin
            write_expect(win_addr(WIN_SRC2, src2_base + idx),
                         {16'hBEEF, tdata[p+4+n1+idx][15:0]}, resp_okay);
        end
        for (idx = 0; idx < n1; idx++) begin
            read_expect(win_addr(WIN_SRC1, src1_base + idx), {16'h0, tdata[p+4+idx][15:0]},
                        resp_okay, $sformatf("src1[%0d]", src1_base + idx));
        end
        for (idx = 0; idx < n2; idx++) begin
            read_expect(win_addr(WIN_SRC2, src2_base + idx), {16'h0, tdata[p+4+n1+idx][15:0]},
                        resp_okay, $sformatf("src2[%0d]", src2_base + idx));
        end
        write_expect(REG_DIMS, dims, resp_okay);
        write_expect(REG_SRC1, src1_base, resp_okay);
        write_expect(REG_SRC2, src2_base, resp_okay);
        write_expect(REG_DEST, dest_base, resp_okay);
        write_expect(REG_CTRL, 32'h1, resp_okay);
        if (steps > 0) begin
            axil_read(REG_STATUS, status, resp);
            check("status after start", 32'h1, status);   // Busy set, old done cleared
        end
        if (steps >= 8) begin
            write_expect(win_addr(WIN_SRC1, src1_base), 32'h0000DEAD, resp_slverr);
            read_expect(win_addr(WIN_SRC2, src2_base), 32'h0, resp_slverr, "rdata while busy");
        end
        status = '0;
        while (!status[1]) begin
            axil_read(REG_STATUS, status, resp);
        end
        check("status at done", 32'h2, status);
        if (steps >= 8) begin
            read_expect(win_addr(WIN_SRC1, src1_base), {16'h0, tdata[p+4][15:0]}, resp_okay,
                        "src1 after rejected write");
        end
        if (nres > 0) begin
            write_expect(win_addr(WIN_DEST, dest_base), 32'hFFFF_FFFF, resp_slverr);
        end
        for (idx = 0; idx < nres; idx++) begin
            dest_model[dest_base + idx] = tdata[res_ptr + idx];
        end
        for (idx = 0; idx < nres + 4; idx++) begin
            read_expect(win_addr(WIN_DEST, guard_lo + idx), dest_model[guard_lo + idx],
                        resp_okay, $sformatf("dest[%0d]", guard_lo + idx));
        end
    endtask

    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d cycles", budget);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] dims;
        int ncases, c, p, n1, n2, nres;
        clk          = 1'b0;
        reset        = 1'b1;
        req          = '0;
        errors       = 0;
        checks       = 0;
        budget       = 200;
        budget_ready = 1'b0;
        $readmemh("verification/matmul_testdata.hex", tdata);
        if (^tdata[0] === 1'bx) begin
            $display("The test data file could not be read");
            errors++;
            ncases = 0;
        end else begin
            ncases = tdata[0];
        end
        p = 1;
        for (c = 0; c < ncases; c++) begin
            dims = tdata[p];
            n1   = dims[5:0] * dims[13:8];
            n2   = dims[13:8] * dims[21:16];
            nres = dims[5:0] * dims[21:16];
            budget += nres * dims[13:8] + 200 + 10 * (2 * (n1 + n2) + nres + 4);
            p += 4 + n1 + n2 + nres;
        end
        budget_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        p = 1;
        for (c = 0; c < ncases; c++) begin
            run_case(p);
            dims = tdata[p];
            p += 4 + dims[5:0] * dims[13:8] + dims[13:8] * dims[21:16]
                 + dims[5:0] * dims[21:16];
        end
        write_expect(16'h0800, 32'h1, resp_slverr);
        read_expect(16'h4000, 32'h0, resp_slverr, "rdata unmapped window");
        read_expect(16'h0018, 32'h0, resp_slverr, "rdata unmapped register");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/matmul_props.sv
`timescale 1ns/1ps

module matmul_props #(
    parameter bit CHECK_AXIL   = 1'b1,
    parameter bit CHECK_RESULT = 1'b1
) (
    input logic                   clk,
    input logic                   reset,
    input mm_axil_pkg::axil_req_t axil_req,
    input mm_axil_pkg::axil_rsp_t axil_rsp,
    input logic                   busy,
    input logic                   result_valid
);

    property held_until_ready(valid, ready);
        @(posedge clk) disable iff (reset) valid && !ready |=> valid;
    endproperty

    if (CHECK_AXIL) begin : g_axil
        aw_held: assert property (held_until_ready(axil_req.awvalid, axil_rsp.awready))
            else $error("awvalid dropped before awready");
        w_held: assert property (held_until_ready(axil_req.wvalid, axil_rsp.wready))
            else $error("wvalid dropped before wready");
        ar_held: assert property (held_until_ready(axil_req.arvalid, axil_rsp.arready))
            else $error("arvalid dropped before arready");
        b_held: assert property (held_until_ready(axil_rsp.bvalid, axil_req.bready))
            else $error("bvalid dropped before bready");
        r_held: assert property (held_until_ready(axil_rsp.rvalid, axil_req.rready))
            else $error("rvalid dropped before rready");

        bresp_stable: assert property (@(posedge clk) disable iff (reset)
            axil_rsp.bvalid && !axil_req.bready |=> $stable(axil_rsp.bresp))
            else $error("bresp changed while bvalid was held");
        rresp_stable: assert property (@(posedge clk) disable iff (reset)
            axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rresp))
            else $error("rresp changed while rvalid was held");
    end

    // Results may only reach the destination RAM during a job
    if (CHECK_RESULT) begin : g_result
        result_in_job: assert property (@(posedge clk) disable iff (reset)
            result_valid |-> busy)
            else $error("result written while the engine was idle");
    end

endmodule

bind mm_csr_axil matmul_props #(.CHECK_AXIL(1'b1), .CHECK_RESULT(1'b0)) u_csr_props (
    .clk(clk),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .busy(busy),
    .result_valid(1'b0)
);

bind dot_mac matmul_props #(.CHECK_AXIL(1'b0), .CHECK_RESULT(1'b1)) u_mac_props (
    .clk(clk),
    .reset(reset),
    .axil_req('0),
    .axil_rsp('0),
    .busy(u_seq.busy),
    .result_valid(result.valid)
);

// File: hdl/matmul_top.sv
`timescale 1ns/1ps

module matmul_top #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mm_axil_pkg::axil_req_t axil_req,
    output mm_axil_pkg::axil_rsp_t axil_rsp
);
    import mm_types_pkg::*;
    import mm_axil_pkg::*;

    mm_job_t    job;
    mm_step_t   step, tag1;
    mm_result_t result;
    logic       start, busy, done_pulse;
    logic [1:0] host_sel;
    mem_addr_t  host_addr, fetch1_addr, fetch2_addr;
    mem_addr_t  src1_addr, src2_addr, dest_addr;
    elem_t      host_wdata, src1_rdata, src2_rdata, operand1, operand2;
    acc_t       dest_rdata;
    logic       host_we, src1_we, src2_we, dest_we;

    mm_csr_axil #(.MEM_DEPTH(MEM_DEPTH)) u_csr (
        .clk(clk),
        .reset(reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .job(job),
        .start(start),
        .busy(busy),
        .done_pulse(done_pulse),
        .host_sel(host_sel),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_we(host_we),
        .host_rdata_elem(host_sel == SEL_SRC2 ? src2_rdata : src1_rdata),
        .host_rdata_acc(dest_rdata)
    );

    mm_sequencer u_seq (
        .clk(clk),
        .reset(reset),
        .start(start),
        .job(job),
        .step(step),
        .busy(busy),
        .done_pulse(done_pulse)
    );

    operand_fetch #(.COLUMN_WALK(1'b0)) u_fetch1 (
        .clk(clk),
        .reset(reset),
        .step(step),
        .job(job),
        .ram_addr(fetch1_addr),
        .ram_rdata(src1_rdata),
        .operand(operand1),
        .tag(tag1)
    );

    operand_fetch #(.COLUMN_WALK(1'b1)) u_fetch2 (
        .clk(clk),
        .reset(reset),
        .step(step),
        .job(job),
        .ram_addr(fetch2_addr),
        .ram_rdata(src2_rdata),
        .operand(operand2),
        .tag()
    );

    dot_mac u_mac (
        .clk(clk),
        .reset(reset),
        .a(operand1),
        .b(operand2),
        .tag(tag1),
        .job(job),
        .result(result)
    );

    // The engine owns every RAM port while a job runs
    assign src1_addr = busy ? fetch1_addr : host_addr;
    assign src2_addr = busy ? fetch2_addr : host_addr;
    assign dest_addr = busy ? result.addr : host_addr;
    assign src1_we   = busy ? 1'b0 : host_we && (host_sel == SEL_SRC1);
    assign src2_we   = busy ? 1'b0 : host_we && (host_sel == SEL_SRC2);
    assign dest_we   = busy ? result.valid : 1'b0;

    scratch_ram #(.word_t(elem_t), .MEM_DEPTH(MEM_DEPTH)) u_src1_ram (
        .clk(clk),
        .addr(src1_addr),
        .we(src1_we),
        .wdata(host_wdata),
        .rdata(src1_rdata)
    );

    scratch_ram #(.word_t(elem_t), .MEM_DEPTH(MEM_DEPTH)) u_src2_ram (
        .clk(clk),
        .addr(src2_addr),
        .we(src2_we),
        .wdata(host_wdata),
        .rdata(src2_rdata)
    );

    scratch_ram #(.word_t(acc_t), .MEM_DEPTH(MEM_DEPTH)) u_dest_ram (
        .clk(clk),
        .addr(dest_addr),
        .we(dest_we),
        .wdata(result.data),
        .rdata(dest_rdata)
    );

endmodule

// File: hdl/dot_mac.sv
`timescale 1ns/1ps

module dot_mac (
    input  logic                     clk,
    input  logic                     reset,
    input  mm_types_pkg::elem_t      a,
    input  mm_types_pkg::elem_t      b,
    input  mm_types_pkg::mm_step_t   tag,
    input  mm_types_pkg::mm_job_t    job,
    output mm_types_pkg::mm_result_t result
);
    import mm_types_pkg::*;

    acc_t      product, acc, sum;
    mem_addr_t res_addr;
    acc_t      res_data;
    logic      res_valid;

    assign product = acc_t'(a) * acc_t'(b);
    assign sum     = tag.first ? product : acc + product;   // Wraps modulo 2^32

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            acc <= sum;
        end
        res_addr <= job.dest_base + mem_addr_t'(tag.i) * mem_addr_t'(job.cols2)
                    + mem_addr_t'(tag.j);
        res_data <= sum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= tag.valid && tag.last;
        end
    end

    always_comb begin
        result.addr  = res_addr;
        result.data  = res_data;
        result.valid = res_valid;
    end

endmodule

// File: hdl/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch #(
    parameter bit COLUMN_WALK = 1'b0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mm_types_pkg::mm_step_t  step,
    input  mm_types_pkg::mm_job_t   job,
    output mm_types_pkg::mem_addr_t ram_addr,
    input  mm_types_pkg::elem_t     ram_rdata,
    output mm_types_pkg::elem_t     operand,
    output mm_types_pkg::mm_step_t  tag
);
    import mm_types_pkg::*;

    mem_addr_t base, major, stride, minor;

    always_comb begin
        if (COLUMN_WALK) begin
            base   = job.src2_base;                 // Walk down column j of source 2
            major  = mem_addr_t'(step.k);
            stride = mem_addr_t'(job.cols2);
            minor  = mem_addr_t'(step.j);
        end else begin
            base   = job.src1_base;                 // Walk along row i of source 1
            major  = mem_addr_t'(step.i);
            stride = mem_addr_t'(job.cols1);
            minor  = mem_addr_t'(step.k);
        end
    end

    assign ram_addr = base + major * stride + minor;
    assign operand  = ram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else begin
            tag <= step;                            // Lines up with the registered RAM read
        end
    end

endmodule

// File: hdl/mm_sequencer.sv
`timescale 1ns/1ps

module mm_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mm_types_pkg::mm_job_t  job,
    output mm_types_pkg::mm_step_t step,
    output logic                   busy,
    output logic                   done_pulse
);
    import mm_types_pkg::*;

    dim_t       i, j, k;
    logic       issuing, draining;
    logic [1:0] drain_cnt;
    logic       zero_dim, last_i, last_j, last_k;

    assign zero_dim = (job.rows1 == '0) || (job.cols1 == '0) || (job.cols2 == '0);
    assign last_i   = (i == job.rows1 - 1'b1);
    assign last_j   = (j == job.cols2 - 1'b1);
    assign last_k   = (k == job.cols1 - 1'b1);

    assign busy       = issuing || draining;
    assign done_pulse = draining && (drain_cnt == 2'd0);

    always_comb begin
        step.i     = i;
        step.j     = j;
        step.k     = k;
        step.first = (k == '0);
        step.last  = last_k;
        step.valid = issuing;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing   <= 1'b0;
            draining  <= 1'b0;
            drain_cnt <= 2'd0;
            i <= '0;
            j <= '0;
            k <= '0;
        end else if (start && !busy) begin
            i <= '0;
            j <= '0;
            k <= '0;
            if (zero_dim) begin
                draining  <= 1'b1;                  // Nothing to compute, done two cycles on
                drain_cnt <= 2'd1;
            end else begin
                issuing <= 1'b1;
            end
        end else if (issuing) begin
            if (!last_k) begin
                k <= k + 1'b1;
            end else begin
                k <= '0;
                if (!last_j) begin
                    j <= j + 1'b1;
                end else begin
                    j <= '0;
                    if (!last_i) begin
                        i <= i + 1'b1;
                    end else begin
                        issuing   <= 1'b0;
                        draining  <= 1'b1;
                        drain_cnt <= 2'd2;          // Covers fetch, MAC and the result write
                    end
                end
            end
        end else if (draining) begin
            if (drain_cnt == 2'd0) draining <= 1'b0;
            else drain_cnt <= drain_cnt - 1'b1;
        end
    end

endmodule

// File: hdl/mm_csr_axil.sv
`timescale 1ns/1ps

module mm_csr_axil #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mm_axil_pkg::axil_req_t  axil_req,
    output mm_axil_pkg::axil_rsp_t  axil_rsp,
    output mm_types_pkg::mm_job_t   job,
    output logic                    start,
    input  logic                    busy,
    input  logic                    done_pulse,
    output logic [1:0]              host_sel,
    output mm_types_pkg::mem_addr_t host_addr,
    output mm_types_pkg::elem_t     host_wdata,
    output logic                    host_we,
    input  mm_types_pkg::elem_t     host_rdata_elem,
    input  mm_types_pkg::acc_t      host_rdata_acc
);
    import mm_types_pkg::*;
    import mm_axil_pkg::*;

    typedef struct packed {
        logic       is_reg;
        logic       is_win;
        logic [1:0] sel;
        mem_addr_t  word;
    } decode_t;

    function automatic decode_t decode(axil_addr_t addr);
        decode_t    d;
        axil_addr_t win_base;
        d = '0;
        win_base = addr & ~WIN_OFFSET_MASK;
        d.word = addr[MEM_ADDR_W+1:2];
        case (addr)
            REG_CTRL, REG_STATUS, REG_DIMS, REG_SRC1, REG_SRC2, REG_DEST: d.is_reg = 1'b1;
            default: d.is_reg = 1'b0;
        endcase
        case (win_base)
            WIN_SRC1: d.sel = SEL_SRC1;
            WIN_SRC2: d.sel = SEL_SRC2;
            WIN_DEST: d.sel = SEL_DEST;
            default:  d.sel = SEL_NONE;
        endcase
        d.is_win = (d.sel != SEL_NONE) && (int'(d.word) < MEM_DEPTH);
        return d;
    endfunction

    logic       aw_taken, w_taken, bvalid;
    axil_resp_t bresp_q, rresp_q;
    axil_addr_t aw_addr_q, wr_addr;
    axil_data_t w_data_q, wr_data;
    logic       aw_hs, w_hs, ar_hs, wr_fire, wr_ok;
    decode_t    wr_dec, rd_dec;
    logic       r_pending, rd_stage, rvalid;
    logic       rd_ok_q, rd_win_q;
    logic [1:0] rd_sel_q;
    axil_data_t rd_reg_q, reg_rdata, rdata_q;
    logic       done_q;

    always_comb begin
        axil_rsp = '0;
        axil_rsp.awready = !aw_taken && !bvalid;
        axil_rsp.wready  = !w_taken && !bvalid;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = !r_pending;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid;
    end

    assign aw_hs = axil_req.awvalid && !aw_taken && !bvalid;
    assign w_hs  = axil_req.wvalid && !w_taken && !bvalid;
    assign ar_hs = axil_req.arvalid && !r_pending;

    assign wr_addr = aw_taken ? aw_addr_q : axil_req.awaddr;
    assign wr_data = w_taken ? w_data_q : axil_req.wdata;
    assign wr_dec  = decode(wr_addr);
    assign rd_dec  = decode(axil_req.araddr);

    // The read owns the RAM port on its handshake and the cycle after
    assign wr_fire = (aw_taken || aw_hs) && (w_taken || w_hs) && !ar_hs && !rd_stage;
    assign wr_ok   = wr_dec.is_reg || (wr_dec.is_win && !busy && wr_dec.sel != SEL_DEST);

    assign host_we    = wr_fire && wr_dec.is_win && wr_ok;
    assign host_wdata = wr_data[15:0];
    assign host_addr  = ar_hs ? rd_dec.word : wr_dec.word;
    assign host_sel   = rd_stage ? rd_sel_q : wr_dec.sel;

    always_comb begin
        reg_rdata = '0;
        case (axil_req.araddr)
            REG_STATUS: reg_rdata = {30'd0, done_q, busy};
            REG_DIMS:   reg_rdata = {10'd0, job.cols2, 2'd0, job.cols1, 2'd0, job.rows1};
            REG_SRC1:   reg_rdata = axil_data_t'(job.src1_base);
            REG_SRC2:   reg_rdata = axil_data_t'(job.src2_base);
            REG_DEST:   reg_rdata = axil_data_t'(job.dest_base);
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_taken  <= 1'b0;
            w_taken   <= 1'b0;
            bvalid    <= 1'b0;
            bresp_q   <= resp_okay;
            r_pending <= 1'b0;
            rd_stage  <= 1'b0;
            rvalid    <= 1'b0;
            rresp_q   <= resp_okay;
            start     <= 1'b0;
            done_q    <= 1'b0;
            job       <= '0;
        end else begin
            start    <= 1'b0;
            rd_stage <= ar_hs;
            if (done_pulse) done_q <= 1'b1;

            if (wr_fire) begin
                aw_taken <= 1'b0;
                w_taken  <= 1'b0;
                bvalid   <= 1'b1;
                if (wr_ok) bresp_q <= resp_okay;
                else bresp_q <= resp_slverr;
            end else begin
                if (aw_hs) aw_taken <= 1'b1;
                if (w_hs) w_taken <= 1'b1;
                if (bvalid && axil_req.bready) bvalid <= 1'b0;
            end

            // Job registers stay frozen while the engine runs
            if (wr_fire && wr_dec.is_reg && !busy) begin
                case (wr_addr)
                    REG_CTRL: begin
                        if (wr_data[0]) begin
                            start  <= 1'b1;
                            done_q <= 1'b0;
                        end
                    end
                    REG_DIMS: begin
                        job.rows1 <= wr_data[5:0];
                        job.cols1 <= wr_data[13:8];
                        job.cols2 <= wr_data[21:16];
                    end
                    REG_SRC1: job.src1_base <= wr_data[MEM_ADDR_W-1:0];
                    REG_SRC2: job.src2_base <= wr_data[MEM_ADDR_W-1:0];
                    REG_DEST: job.dest_base <= wr_data[MEM_ADDR_W-1:0];
                    default: ;
                endcase
            end

            if (ar_hs) r_pending <= 1'b1;
            if (rd_stage) begin
                rvalid <= 1'b1;
                if (rd_ok_q) rresp_q <= resp_okay;
                else rresp_q <= resp_slverr;
            end else if (rvalid && axil_req.rready) begin
                rvalid    <= 1'b0;
                r_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_addr_q <= axil_req.awaddr;
        if (w_hs) w_data_q <= axil_req.wdata;
        if (ar_hs) begin
            rd_ok_q  <= rd_dec.is_reg || (rd_dec.is_win && !busy);
            rd_win_q <= rd_dec.is_win;
            rd_sel_q <= rd_dec.sel;
            rd_reg_q <= reg_rdata;
        end
        if (rd_stage) begin
            if (!rd_ok_q) rdata_q <= '0;                    // Rejected reads return zero
            else if (!rd_win_q) rdata_q <= rd_reg_q;
            else if (rd_sel_q == SEL_DEST) rdata_q <= host_rdata_acc;
            else rdata_q <= axil_data_t'(host_rdata_elem);
        end
    end

endmodule

// File: hdl/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
    parameter type word_t    = mm_types_pkg::elem_t,
    parameter int  MEM_DEPTH = 1024
) (
    input  logic                    clk,
    input  mm_types_pkg::mem_addr_t addr,
    input  logic                    we,
    input  word_t                   wdata,
    output word_t                   rdata
);

    word_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                         // Read returns the old word on a write
    end

endmodule

// File: hdl/mm_axil_pkg.sv
package mm_axil_pkg;

    localparam int AXIL_ADDR_W = 16;
    localparam int AXIL_DATA_W = 32;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_t;

    typedef struct packed {
        axil_addr_t                   awaddr;
        logic                         awvalid;
        axil_data_t                   wdata;
        logic [AXIL_DATA_W/8-1:0]     wstrb;
        logic                         wvalid;
        logic                         bready;
        axil_addr_t                   araddr;
        logic                         arvalid;
        logic                         rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    localparam axil_addr_t REG_CTRL   = 16'h0000;
    localparam axil_addr_t REG_STATUS = 16'h0004;
    localparam axil_addr_t REG_DIMS   = 16'h0008;
    localparam axil_addr_t REG_SRC1   = 16'h000C;
    localparam axil_addr_t REG_SRC2   = 16'h0010;
    localparam axil_addr_t REG_DEST   = 16'h0014;

    // Each window spans 1024 words at byte stride 4
    localparam axil_addr_t WIN_SRC1        = 16'h1000;
    localparam axil_addr_t WIN_SRC2        = 16'h2000;
    localparam axil_addr_t WIN_DEST        = 16'h3000;
    localparam axil_addr_t WIN_OFFSET_MASK = 16'h0FFF;

    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_SRC1 = 2'd1;
    localparam logic [1:0] SEL_SRC2 = 2'd2;
    localparam logic [1:0] SEL_DEST = 2'd3;

endpackage

// File: hdl/mm_types_pkg.sv
package mm_types_pkg;

    localparam int MEM_ADDR_W = 10;

    typedef logic [15:0] elem_t;            // Operand element
    typedef logic [31:0] acc_t;             // Result element, wraps modulo 2^32
    typedef logic [5:0] dim_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Job description handed from the register block to the engine
    typedef struct packed {
        dim_t      rows1;
        dim_t      cols1;                   // Also the row count of source 2
        dim_t      cols2;
        mem_addr_t src1_base;
        mem_addr_t src2_base;
        mem_addr_t dest_base;
    } mm_job_t;

    typedef struct packed {
        dim_t i;
        dim_t j;
        dim_t k;
        logic first;                        // Step with k equal to zero
        logic last;                         // Step with k equal to cols1 - 1
        logic valid;
    } mm_step_t;

    typedef struct packed {
        mem_addr_t addr;
        acc_t      data;
        logic      valid;
    } mm_result_t;

endpackage
